//--- shade_pkg.sv
package shade_pkg;

    ////////////////////
    // number format
    ////////////////////

    // signed fixed point, 16 fraction bits
    localparam int FRAC_BITS = 16;

    typedef logic signed [31:0] fixed_t;

    localparam fixed_t FIX_ONE = 32'sh0001_0000;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } vec3_t;

    typedef struct packed {
        fixed_t r;
        fixed_t g;
        fixed_t b;
    } rgb_t;

    ////////////////////
    // block description
    ////////////////////

    typedef enum logic {
        BLUE,
        RED
    } color_e;

    // arrow heading drawn on the top face
    typedef enum logic [2:0] {
        UP,
        RIGHT,
        DOWN,
        LEFT,
        ANY
    } dir_e;

    typedef struct packed {
        vec3_t  pos;
        color_e color;
        dir_e   dir;
    } block_info_t;

    ////////////////////
    // geometry
    ////////////////////

    // world offset of the block grid, 1800.0 on both axes
    localparam fixed_t BLOCK_ORIGIN_X = 32'sh0708_0000;
    localparam fixed_t BLOCK_ORIGIN_Y = 32'sh0708_0000;

    // top face sits 200.0 above the block position
    localparam fixed_t TWO_BLOCK_SIZE = 32'sh00C8_0000;

    // pipeline latencies
    localparam int HIT_SCALE_STAGES = 2;
    localparam int ARROW_STAGES     = 3;

endpackage

//--- pipe_delay.sv
`timescale 1ns/100ps

module pipe_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk_in,
    input  logic rst_in,
    input  T     d,
    output T     q
);

    // register chain, index 0 is the input side
    T stage [DEPTH];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= T'('0);
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

//--- ray_scale.sv
`timescale 1ns/100ps

module ray_scale (
    input  logic              clk_in,
    input  logic              rst_in,
    input  shade_pkg::vec3_t  ray,
    input  shade_pkg::fixed_t t,
    input  logic              valid_in,
    output shade_pkg::vec3_t  hit,
    output logic              hit_valid
);
    import shade_pkg::*;

    typedef logic signed [63:0] wide_t;

    // full width products
    wide_t prod_x;
    wide_t prod_y;
    wide_t prod_z;
    logic  prod_valid;

    // drop the extra fraction bits, keep the low word
    function automatic fixed_t fix_trunc(input wide_t p);
        return fixed_t'(p >>> FRAC_BITS);
    endfunction

    // stage 1
    always_ff @(posedge clk_in) begin
        prod_x <= $signed(ray.x) * $signed(t);
        prod_y <= $signed(ray.y) * $signed(t);
        prod_z <= $signed(ray.z) * $signed(t);
    end

    // stage 2
    always_ff @(posedge clk_in) begin
        hit.x <= fix_trunc(prod_x);
        hit.y <= fix_trunc(prod_y);
        hit.z <= fix_trunc(prod_z);
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            prod_valid <= 1'b0;
            hit_valid  <= 1'b0;
        end else begin
            prod_valid <= valid_in;
            hit_valid  <= prod_valid;
        end
    end

endmodule

//--- arrow_face_test.sv
`timescale 1ns/100ps

module arrow_face_test #(
    parameter shade_pkg::fixed_t ARROW_HALF_WIDTH = 32'sh0050_0000,
    parameter shade_pkg::fixed_t FACE_EPS         = 32'sh0000_028F
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  shade_pkg::vec3_t       hit,
    input  shade_pkg::block_info_t block,
    input  logic                   valid_in,
    output logic                   arrow,
    output logic                   arrow_valid
);
    import shade_pkg::*;

    // in-plane block position, combinational
    fixed_t n_x;
    fixed_t n_y;

    ////////////////////
    // stage 1 registers
    ////////////////////
    fixed_t s1_face_diff;
    fixed_t s1_n_x;
    fixed_t s1_n_y;
    fixed_t s1_ray_sum;
    fixed_t s1_ray_diff;
    fixed_t s1_blk_sum;
    fixed_t s1_blk_diff;
    fixed_t s1_x_lo;
    fixed_t s1_x_hi;
    fixed_t s1_y_lo;
    fixed_t s1_y_hi;
    fixed_t s1_h_x;
    fixed_t s1_h_y;
    dir_e   s1_dir;
    logic   s1_valid;

    ////////////////////
    // stage 2 registers
    ////////////////////
    logic s2_face;
    logic s2_a;
    logic s2_c;
    logic s2_box;
    logic s2_xlt;
    logic s2_ylt;
    dir_e s2_dir;
    logic s2_valid;

    always_comb begin
        n_x = block.pos.x - BLOCK_ORIGIN_X;
        n_y = block.pos.y - BLOCK_ORIGIN_Y;
    end

    // stage 1
    // differences and bounds, all wrapping at 32 bits
    always_ff @(posedge clk_in) begin
        s1_face_diff <= hit.z - block.pos.z - TWO_BLOCK_SIZE;
        s1_n_x       <= n_x;
        s1_n_y       <= n_y;
        s1_ray_sum   <= hit.y + hit.x;
        s1_ray_diff  <= hit.y - hit.x;
        s1_blk_sum   <= n_y + n_x;
        s1_blk_diff  <= n_y - n_x;
        s1_x_lo      <= n_x - ARROW_HALF_WIDTH;
        s1_x_hi      <= n_x + ARROW_HALF_WIDTH;
        s1_y_lo      <= n_y - ARROW_HALF_WIDTH;
        s1_y_hi      <= n_y + ARROW_HALF_WIDTH;
        s1_h_x       <= hit.x;
        s1_h_y       <= hit.y;
        s1_dir       <= block.dir;
    end

    // stage 2
    // a and c split the face along its two diagonals
    always_ff @(posedge clk_in) begin
        s2_face <= (s1_face_diff <= FACE_EPS);
        s2_a    <= (s1_ray_sum < s1_blk_sum);
        s2_c    <= (s1_ray_diff < s1_blk_diff);
        s2_box  <= (s1_y_lo < s1_h_y) && (s1_h_y < s1_y_hi) &&
                   (s1_x_lo < s1_h_x) && (s1_h_x < s1_x_hi);
        s2_xlt  <= (s1_h_x < s1_n_x);
        s2_ylt  <= (s1_h_y < s1_n_y);
        s2_dir  <= s1_dir;
    end

    // stage 3
    // pick the triangle that matches the heading
    always_ff @(posedge clk_in) begin
        case (s2_dir)
            DOWN: begin
                arrow <= s2_face && s2_box && s2_ylt && s2_a && s2_c;
            end
            LEFT: begin
                arrow <= s2_face && s2_box && !s2_xlt && !s2_a && s2_c;
            end
            UP: begin
                arrow <= s2_face && s2_box && !s2_ylt && !s2_a && !s2_c;
            end
            // RIGHT and ANY share one triangle
            default: begin
                arrow <= s2_face && s2_box && s2_xlt && s2_a && !s2_c;
            end
        endcase
    end

    ////////////////////
    // valid chain
    ////////////////////
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid    <= 1'b0;
            s2_valid    <= 1'b0;
            arrow_valid <= 1'b0;
        end else begin
            s1_valid    <= valid_in;
            s2_valid    <= s1_valid;
            arrow_valid <= s2_valid;
        end
    end

endmodule

//--- pixel_color_out.sv
`timescale 1ns/100ps

module pixel_color_out (
    input  logic              clk_in,
    input  logic              rst_in,
    input  shade_pkg::color_e color,
    input  logic              arrow,
    input  logic              valid_in,
    output shade_pkg::rgb_t   rgb,
    output logic              rgb_valid
);
    import shade_pkg::*;

    rgb_t next_rgb;

    // unit material color, white on the arrow
    always_comb begin
        if (arrow) begin
            next_rgb.r = FIX_ONE;
            next_rgb.g = FIX_ONE;
            next_rgb.b = FIX_ONE;
        end else if (color == RED) begin
            next_rgb.r = FIX_ONE;
            next_rgb.g = '0;
            next_rgb.b = '0;
        end else begin
            next_rgb.r = '0;
            next_rgb.g = '0;
            next_rgb.b = FIX_ONE;
        end
    end

    always_ff @(posedge clk_in) begin
        rgb <= next_rgb;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= valid_in;
        end
    end

endmodule

//--- pixel_shade_top.sv
`timescale 1ns/100ps

module pixel_shade_top #(
    parameter shade_pkg::fixed_t ARROW_HALF_WIDTH = 32'sh0050_0000,
    parameter shade_pkg::fixed_t FACE_EPS         = 32'sh0000_028F
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  shade_pkg::block_info_t block,
    input  shade_pkg::vec3_t       ray,
    input  shade_pkg::fixed_t      t,
    input  logic                   valid_in,
    output shade_pkg::rgb_t        rgb,
    output logic                   rgb_valid
);
    import shade_pkg::*;

    vec3_t       hit;
    logic        hit_valid;
    block_info_t block_d;
    logic        arrow;
    logic        arrow_valid;
    color_e      color_d;

    // hit point, 2 cycles
    ray_scale u_ray_scale (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .ray       (ray),
        .t         (t),
        .valid_in  (valid_in),
        .hit       (hit),
        .hit_valid (hit_valid)
    );

    pipe_delay #(.T(block_info_t), .DEPTH(HIT_SCALE_STAGES)) u_block_dly (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .d      (block),
        .q      (block_d)
    );

    // arrow flag, 3 cycles
    arrow_face_test #(
        .ARROW_HALF_WIDTH (ARROW_HALF_WIDTH),
        .FACE_EPS         (FACE_EPS)
    ) u_arrow_face_test (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .hit         (hit),
        .block       (block_d),
        .valid_in    (hit_valid),
        .arrow       (arrow),
        .arrow_valid (arrow_valid)
    );

    pipe_delay #(.T(color_e), .DEPTH(ARROW_STAGES)) u_color_dly (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .d      (block_d.color),
        .q      (color_d)
    );

    pixel_color_out u_pixel_color_out (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .color     (color_d),
        .arrow     (arrow),
        .valid_in  (arrow_valid),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

endmodule

//--- pixel_shade_sva.sv
`timescale 1ns/100ps

module pixel_shade_sva (
    input logic            clk_in,
    input logic            rst_in,
    input logic            valid_in,
    input shade_pkg::rgb_t rgb,
    input logic            rgb_valid
);

    // cycles since reset release, saturates at the pipeline depth
    logic [2:0] settle;

    // failed assertion count
    int assert_failures = 0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            settle <= 3'd0;
        end else if (settle != 3'd6) begin
            settle <= settle + 3'd1;
        end
    end

    valid_after_reset: assert property (@(posedge clk_in) rst_in |=> !rgb_valid)
        else begin
            assert_failures++;
            $error("rgb_valid high in the cycle after reset");
        end

    // output strobe is the input strobe six cycles later
    valid_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        (settle == 3'd6) |-> (rgb_valid == $past(valid_in, 6)))
        else begin
            assert_failures++;
            $error("rgb_valid does not follow valid_in by six cycles");
        end

    rgb_known: assert property (@(posedge clk_in) disable iff (rst_in)
        rgb_valid |-> !$isunknown(rgb))
        else begin
            assert_failures++;
            $error("rgb has unknown bits while rgb_valid is high");
        end

endmodule

//--- pixel_shade_checker.sv
`timescale 1ns/100ps

module pixel_shade_checker (
    input logic            clk_in,
    input logic            rst_in,
    input logic            valid_in,
    input shade_pkg::rgb_t rgb,
    input logic            rgb_valid
);
    import shade_pkg::*;

    localparam int LATENCY = 6;

    typedef struct packed {
        rgb_t exp_rgb;
        logic exp_arrow;
        int   row_id;
    } expect_t;

    expect_t exp_q [$];
    // cycle number of every accepted input, oldest first
    int      stamp_q [$];
    int      cycle          = 0;
    int      rgb_errors     = 0;
    int      latency_errors = 0;
    int      stray_errors   = 0;
    expect_t head;
    int      stamp;

    task automatic expect_rgb(input rgb_t exp_rgb, input logic exp_arrow, input int row_id);
        expect_t e;
        e.exp_rgb   = exp_rgb;
        e.exp_arrow = exp_arrow;
        e.row_id    = row_id;
        exp_q.push_back(e);
    endtask

    function automatic int pending_count();
        return exp_q.size();
    endfunction

    always @(posedge clk_in) begin
        cycle <= cycle + 1;
        if (!rst_in && valid_in) begin
            stamp_q.push_back(cycle);
        end
        if (!rst_in && rgb_valid) begin
            if (exp_q.size() == 0 || stamp_q.size() == 0) begin
                stray_errors++;
                $display("rgb_valid was high at time %0d ns with no sample in flight", $time);
            end else begin
                head  = exp_q.pop_front();
                stamp = stamp_q.pop_front();
                if (rgb !== head.exp_rgb) begin
                    rgb_errors++;
                    $display("** Error at time %0d ns: rgb (row %0d, arrow %0b) expected %h got %h",
                             $time, head.row_id, head.exp_arrow, head.exp_rgb, rgb);
                end
                if (cycle - stamp != LATENCY) begin
                    latency_errors++;
                    $display("** Error at time %0d ns: rgb_valid latency expected %0d got %0d",
                             $time, LATENCY, cycle - stamp);
                end
            end
        end
    end

endmodule

//--- pixel_shade_tb.sv
`timescale 1ns/100ps

module pixel_shade_tb;
    import shade_pkg::*;

    localparam int unsigned SEED        = 32'hd2f2_a140;
    localparam int          DRAIN_LIMIT = 40;

    localparam fixed_t HALF      = 32'sh0000_8000;
    localparam rgb_t   WHITE_RGB = {FIX_ONE, FIX_ONE, FIX_ONE};
    localparam rgb_t   RED_RGB   = {FIX_ONE, 32'sd0, 32'sd0};
    localparam rgb_t   BLUE_RGB  = {32'sd0, 32'sd0, FIX_ONE};

    typedef struct packed {
        block_info_t block;
        vec3_t       ray;
        fixed_t      t;
        logic        exp_arrow;
        rgb_t        exp_rgb;
    } row_t;

    logic        clk_in = 1'b0;
    logic        rst_in;
    block_info_t block;
    vec3_t       ray;
    fixed_t      t;
    logic        valid_in;
    rgb_t        rgb;
    logic        rgb_valid;

    row_t rows [$];
    int   gap;
    int   sent;
    int   waited;
    int   total_errors;
    logic timed_out;

    pixel_shade_top dut0 (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .block     (block),
        .ray       (ray),
        .t         (t),
        .valid_in  (valid_in),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

    pixel_shade_checker u_checker (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

    bind pixel_shade_top pixel_shade_sva u_sva (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .rgb       (rgb),
        .rgb_valid (rgb_valid)
    );

    always #4 clk_in = ~clk_in;

    ////////////////////
    // table helpers
    ////////////////////
    function automatic fixed_t fx(input int v);
        return fixed_t'(v) <<< FRAC_BITS;
    endfunction

    function automatic vec3_t v3(input fixed_t x, input fixed_t y, input fixed_t z);
        vec3_t v;
        v.x = x;
        v.y = y;
        v.z = z;
        return v;
    endfunction

    // whole-number point
    function automatic vec3_t pt(input int x, input int y, input int z);
        return v3(fx(x), fx(y), fx(z));
    endfunction

    function automatic block_info_t blk(input int bx, input int by, input int bz,
                                        input color_e c, input dir_e d);
        block_info_t b;
        b.pos   = pt(bx, by, bz);
        b.color = c;
        b.dir   = d;
        return b;
    endfunction

    task automatic add_row(input block_info_t b, input vec3_t r, input fixed_t tv,
                           input logic exp_arrow, input rgb_t exp_rgb);
        row_t row;
        row.block     = b;
        row.ray       = r;
        row.t         = tv;
        row.exp_arrow = exp_arrow;
        row.exp_rgb   = exp_rgb;
        rows.push_back(row);
    endtask

    task automatic build_table();
        // off the top face
        add_row(blk(1800, 1800, 0, RED, UP), pt(0, 40, 210), FIX_ONE, 1'b0, RED_RGB);
        add_row(blk(1800, 1800, 0, BLUE, DOWN), pt(0, -40, 210), FIX_ONE, 1'b0, BLUE_RGB);
        // inside each triangle
        add_row(blk(1800, 1800, 0, RED, UP), pt(0, 40, 200), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), pt(-40, 0, 200), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, RED, DOWN), pt(0, -40, 200), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, LEFT), pt(40, 0, 200), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, ANY), pt(-40, 0, 200), FIX_ONE, 1'b1, WHITE_RGB);
        // same points, wrong heading
        add_row(blk(1800, 1800, 0, RED, DOWN), pt(0, 40, 200), FIX_ONE, 1'b0, RED_RGB);
        add_row(blk(1800, 1800, 0, BLUE, LEFT), pt(-40, 0, 200), FIX_ONE, 1'b0, BLUE_RGB);
        add_row(blk(1800, 1800, 0, RED, UP), pt(40, 0, 200), FIX_ONE, 1'b0, RED_RGB);
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), pt(0, -40, 200), FIX_ONE, 1'b0, BLUE_RGB);
        // box edges, strict
        add_row(blk(1800, 1800, 0, RED, RIGHT), pt(-100, 0, 200), FIX_ONE, 1'b0, RED_RGB);
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), pt(-80, 0, 200), FIX_ONE, 1'b0, BLUE_RGB);
        add_row(blk(1800, 1800, 0, RED, RIGHT), pt(-79, 0, 200), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, UP), pt(0, 100, 200), FIX_ONE, 1'b0, BLUE_RGB);
        // block away from the grid origin, n = (100, -100)
        add_row(blk(1900, 1700, 50, RED, UP), pt(100, -60, 250), FIX_ONE, 1'b1, WHITE_RGB);
        add_row(blk(1900, 1700, 50, RED, LEFT), pt(100, -60, 250), FIX_ONE, 1'b0, RED_RGB);
        // t = 0.5, face difference 655, 655 after floor, 656
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), v3(fx(-80), 0, 32'sd26215710),
                HALF, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), v3(fx(-80), 0, 32'sd26215711),
                HALF, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), v3(fx(-80), 0, 32'sd26215712),
                HALF, 1'b0, BLUE_RGB);
        // negative z, the shift floors toward minus infinity
        add_row(blk(1800, 1800, -400, RED, RIGHT), v3(fx(-80), 0, -32'sd26213090),
                HALF, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, -400, RED, RIGHT), v3(fx(-80), 0, -32'sd26213089),
                HALF, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, -400, RED, RIGHT), v3(fx(-80), 0, -32'sd26213088),
                HALF, 1'b0, RED_RGB);
        // t = -0.5 and t = 2.5
        add_row(blk(1800, 1800, 0, BLUE, RIGHT), pt(80, 0, -400), -HALF, 1'b1, WHITE_RGB);
        add_row(blk(1800, 1800, 0, RED, RIGHT), pt(-16, 0, 80), 32'sh0002_8000, 1'b1, WHITE_RGB);
    endtask

    task automatic drive_row(input row_t r, input int id);
        block    <= r.block;
        ray      <= r.ray;
        t        <= r.t;
        valid_in <= 1'b1;
        u_checker.expect_rgb(r.exp_rgb, r.exp_arrow, id);
    endtask

    initial begin
        rst_in    = 1'b1;
        block     = '0;
        ray       = '0;
        t         = '0;
        valid_in  = 1'b0;
        timed_out = 1'b0;
        sent      = 0;
        void'($urandom(SEED));
        build_table();
        repeat (2) @(posedge clk_in);
        rst_in <= 1'b0;

        // first pass with random idle gaps, second pass back to back
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < rows.size(); i++) begin
                gap = (pass == 0) ? int'($urandom % 3) : 0;
                repeat (gap) begin
                    @(posedge clk_in);
                    valid_in <= 1'b0;
                end
                @(posedge clk_in);
                drive_row(rows[i], sent);
                sent++;
            end
        end
        @(posedge clk_in);
        valid_in <= 1'b0;

        waited = 0;
        while (u_checker.pending_count() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk_in);
            waited++;
        end
        if (u_checker.pending_count() != 0) begin
            timed_out = 1'b1;
            $display("timed out: %0d expected outputs never arrived", u_checker.pending_count());
        end
        // idle tail catches stray strobes
        repeat (8) @(posedge clk_in);

        total_errors = u_checker.rgb_errors + u_checker.latency_errors + u_checker.stray_errors
                       + dut0.u_sva.assert_failures;
        $display("errors: rgb %0d, latency %0d, unexpected %0d, assertion %0d, timeout %0d",
                 u_checker.rgb_errors, u_checker.latency_errors, u_checker.stray_errors,
                 dut0.u_sva.assert_failures, timed_out);
        if (total_errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
shade_pkg.sv
pipe_delay.sv
ray_scale.sv
arrow_face_test.sv
pixel_color_out.sv
pixel_shade_top.sv
pixel_shade_sva.sv
pixel_shade_checker.sv
pixel_shade_tb.sv

//--- Makefile
TOP := pixel_shade_tb

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
